// ==== verilog.f ====
verilog/mpeg_sys_pkg.sv
verilog/bit_deserializer.sv
verilog/start_code_scanner.sv
verilog/header_field_capture.sv
verilog/system_header_parser.sv
verilog/header_regs_axil.sv
verilog/mpeg_sys_parser_top.sv
test/mpeg_sys_parser_asserts.sv
test/mpeg_sys_parser_tb.sv

// ==== Bender.yml ====
package:
  name: mpeg_sys_parser

sources:
  - verilog/mpeg_sys_pkg.sv
  - verilog/bit_deserializer.sv
  - verilog/start_code_scanner.sv
  - verilog/header_field_capture.sv
  - verilog/system_header_parser.sv
  - verilog/header_regs_axil.sv
  - verilog/mpeg_sys_parser_top.sv
  - target: test
    files:
      - test/mpeg_sys_parser_asserts.sv
      - test/mpeg_sys_parser_tb.sv

// ==== test/mpeg_sys_parser_tb.sv ====
// MPEG-1 system stream parser testbench
// directed stream tests with register readback over AXI4-Lite

`timescale 1ns/100ps
`default_nettype none

module mpeg_sys_parser_tb;

	localparam int wait_limit = 200; // cycles per handshake wait

	logic clk;
	logic arst_n;
	logic clk_en;
	logic bit_in;
	mpeg_sys_pkg::axil_req_t axil_req;
	mpeg_sys_pkg::axil_rsp_t axil_rsp;

	int err_count;
	int test_count;
	logic timeout_hit;
	logic use_gaps;
	logic [31:0] rng_state;
	logic [7:0] exp_pack, exp_sys;
	logic exp_end;
	logic [7:0] pack_payload [0:7];
	logic [7:0] sys_payload [0:16]; // fixed part then three entries

	mpeg_sys_parser_top mpeg_sys_parser_top_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.clk_en   (clk_en),
		.bit_in   (bit_in),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] next_random(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// register map layout of reg_status
	function automatic logic [31:0] status_word(input logic e, input logic [7:0] p,
		input logic [7:0] s);
		return {8'd0, s, p, 7'd0, e};
	endfunction

	task automatic stall(input string what);
		$display("timeout: %s did not happen in time", what);
		timeout_hit = 1'b1;
		wait (1'b0); // the watcher ends the run
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			err_count++;
		end
	endtask

	task automatic check_true(input string what, input logic cond);
		assert (cond)
		else
		begin
			$display("error: %s", what);
			err_count++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		$display("test %s finished with %0d errors", name, err_count - errs_before);
	endtask

	// MSB first, random idle cycles between bits when gaps are on
	task automatic send_byte(input logic [7:0] b);
		int gap;
		for (int i = 7; i >= 0; i--)
		begin
			if (use_gaps)
			begin
				rng_state = next_random(rng_state);
				gap = rng_state[1:0];
				clk_en = 1'b0;
				repeat (gap)
				begin
					@(posedge clk);
					#2;
				end
			end
			clk_en = 1'b1;
			bit_in = b[i];
			@(posedge clk);
			#2;
		end
		clk_en = 1'b0;
	endtask

	task automatic send_prefix(input logic [7:0] code);
		send_byte(8'h00);
		send_byte(8'h00);
		send_byte(8'h01);
		send_byte(code);
	endtask

	task automatic send_pack_header();
		send_prefix(mpeg_sys_pkg::pack_start_code);
		for (int i = 0; i < 8; i++)
			send_byte(pack_payload[i]);
	endtask

	task automatic send_sys_header();
		send_prefix(mpeg_sys_pkg::sys_start_code);
		for (int i = 0; i < 17; i++)
			send_byte(sys_payload[i]);
	endtask

	// trailing filler pushes the last byte through the pipeline
	task automatic flush_stream();
		send_byte(8'hFF);
		send_byte(8'hFF);
	endtask

	task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int n;
		axil_req.awaddr  = addr;
		axil_req.awvalid = 1'b1;
		axil_req.wdata   = data;
		axil_req.wstrb   = 4'hF;
		axil_req.wvalid  = 1'b1;
		axil_req.bready  = 1'b0; // response held off for one cycle
		n = 0;
		@(negedge clk);
		while (!axil_rsp.awready && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (!axil_rsp.awready)
			stall("write acceptance");
		check_true("wready not raised with awready", axil_rsp.wready);
		@(posedge clk);
		#2;
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		n = 0;
		@(negedge clk);
		while (!axil_rsp.bvalid && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (!axil_rsp.bvalid)
			stall("write response");
		resp = axil_rsp.bresp;
		@(posedge clk);
		#2;
		check_true("bvalid dropped while bready was low", axil_rsp.bvalid);
		axil_req.bready = 1'b1;
		@(posedge clk);
		#2;
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int n;
		axil_req.araddr  = addr;
		axil_req.arvalid = 1'b1;
		axil_req.rready  = 1'b1;
		n = 0;
		@(negedge clk);
		while (!axil_rsp.arready && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (!axil_rsp.arready)
			stall("read acceptance");
		@(posedge clk);
		#2;
		axil_req.arvalid = 1'b0;
		n = 0;
		@(negedge clk);
		while (!axil_rsp.rvalid && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (!axil_rsp.rvalid)
			stall("read response");
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(posedge clk);
		#2;
		axil_req.rready = 1'b0;
	endtask

	task automatic read_check(input string name, input logic [7:0] addr,
		input logic [31:0] exp);
		logic [31:0] data;
		logic [1:0] resp;
		axil_read(addr, data, resp);
		check_value(name, data, exp);
		check_value({name, " rresp"}, resp, mpeg_sys_pkg::resp_okay);
	endtask

	// poll until the done pulses have landed in the counters
	task automatic wait_status(input logic [31:0] exp);
		logic [31:0] data;
		logic [1:0] resp;
		int n;
		n = 0;
		axil_read(mpeg_sys_pkg::reg_status, data, resp);
		while (data !== exp && n < 60)
		begin
			axil_read(mpeg_sys_pkg::reg_status, data, resp);
			n++;
		end
		if (data !== exp)
			stall("status register update");
	endtask

	task automatic check_pack_regs();
		read_check("scr_lo", mpeg_sys_pkg::reg_scr_lo,
			{pack_payload[1], pack_payload[2], pack_payload[3], pack_payload[4]});
		read_check("scr_hi", mpeg_sys_pkg::reg_scr_hi, {24'd0, pack_payload[0]});
		read_check("mux_rate", mpeg_sys_pkg::reg_mux_rate,
			{8'd0, pack_payload[5], pack_payload[6], pack_payload[7]});
	endtask

	task automatic check_sys_regs();
		read_check("hdr_len", mpeg_sys_pkg::reg_hdr_len, {16'd0, sys_payload[0], sys_payload[1]});
		read_check("rate_bound", mpeg_sys_pkg::reg_rate_bound,
			{8'd0, sys_payload[2], sys_payload[3], sys_payload[4]});
		read_check("flags", mpeg_sys_pkg::reg_flags,
			{8'd0, sys_payload[5], sys_payload[6], sys_payload[7]});
		// entries C0 and E0 share slot 0, C5 lands in slot 5
		read_check("bound slot 0", mpeg_sys_pkg::reg_bound_base + 8'h00,
			{16'd0, sys_payload[12], sys_payload[13]});
		read_check("bound slot 5", mpeg_sys_pkg::reg_bound_base + 8'h14,
			{16'd0, sys_payload[15], sys_payload[16]});
		read_check("bound slot 3", mpeg_sys_pkg::reg_bound_base + 8'h0C, 32'd0);
	endtask

	task automatic pack_header_case();
		int e0;
		e0 = err_count;
		send_byte(8'hFF);
		send_byte(8'h47);
		send_pack_header();
		flush_stream();
		exp_pack = exp_pack + 8'd1;
		wait_status(status_word(exp_end, exp_pack, exp_sys));
		check_pack_regs();
		report_test("pack header", e0);
	endtask

	task automatic system_header_case();
		int e0;
		e0 = err_count;
		send_sys_header();
		flush_stream();
		exp_sys = exp_sys + 8'd1;
		wait_status(status_word(exp_end, exp_pack, exp_sys));
		check_sys_regs();
		report_test("system header", e0);
	endtask

	task automatic prefix_corner_case();
		int e0;
		e0 = err_count;
		send_byte(8'h00); // short prefix
		send_byte(8'h01);
		send_byte(mpeg_sys_pkg::pack_start_code);
		for (int i = 0; i < 8; i++)
			send_byte(pack_payload[i]);
		send_byte(8'h00); // wrong third byte
		send_byte(8'h00);
		send_byte(8'h02);
		send_byte(mpeg_sys_pkg::pack_start_code);
		for (int i = 0; i < 8; i++)
			send_byte(pack_payload[i]);
		send_byte(8'h00); // extra leading zero still matches
		send_pack_header();
		flush_stream();
		exp_pack = exp_pack + 8'd1;
		wait_status(status_word(exp_end, exp_pack, exp_sys));
		read_check("status", mpeg_sys_pkg::reg_status, status_word(exp_end, exp_pack, exp_sys));
		report_test("prefix corners", e0);
	endtask

	task automatic clock_enable_case();
		int e0;
		e0 = err_count;
		use_gaps = 1'b1;
		send_byte(8'hFF);
		send_pack_header();
		send_sys_header();
		flush_stream();
		use_gaps = 1'b0;
		exp_pack = exp_pack + 8'd1;
		exp_sys  = exp_sys + 8'd1;
		wait_status(status_word(exp_end, exp_pack, exp_sys));
		check_pack_regs();
		check_sys_regs();
		report_test("clock enable gaps", e0);
	endtask

	task automatic end_and_clear_case();
		logic [31:0] data;
		logic [1:0] resp;
		int e0;
		e0 = err_count;
		send_prefix(mpeg_sys_pkg::end_code);
		flush_stream();
		exp_end = 1'b1;
		wait_status(status_word(exp_end, exp_pack, exp_sys));
		axil_write(mpeg_sys_pkg::reg_status, 32'h1, resp);
		check_value("bresp clear", {30'd0, resp}, {30'd0, mpeg_sys_pkg::resp_okay});
		exp_end  = 1'b0;
		exp_pack = 8'd0;
		exp_sys  = 8'd0;
		read_check("status", mpeg_sys_pkg::reg_status, 32'd0);
		axil_write(mpeg_sys_pkg::reg_scr_lo, 32'h5A5A_5A5A, resp);
		check_value("bresp scr_lo", {30'd0, resp}, {30'd0, mpeg_sys_pkg::resp_slverr});
		axil_read(8'h40, data, resp);
		check_value("rresp 40", {30'd0, resp}, {30'd0, mpeg_sys_pkg::resp_slverr});
		report_test("end code and clear", e0);
	endtask

	task automatic read_backpressure_case();
		logic [31:0] exp;
		int n;
		int e0;
		e0 = err_count;
		exp = {pack_payload[1], pack_payload[2], pack_payload[3], pack_payload[4]};
		axil_req.araddr  = mpeg_sys_pkg::reg_scr_lo;
		axil_req.arvalid = 1'b1;
		axil_req.rready  = 1'b0;
		n = 0;
		@(negedge clk);
		while (!axil_rsp.arready && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (!axil_rsp.arready)
			stall("read acceptance");
		@(posedge clk);
		#2;
		axil_req.araddr = mpeg_sys_pkg::reg_mux_rate; // second request stays pending
		repeat (6)
		begin
			@(negedge clk);
			check_true("rvalid dropped while rready was low", axil_rsp.rvalid);
			check_value("rdata", axil_rsp.rdata, exp);
			check_true("second read accepted under back-pressure", !axil_rsp.arready);
		end
		@(posedge clk);
		#2;
		axil_req.arvalid = 1'b0;
		axil_req.rready  = 1'b1;
		n = 0;
		@(negedge clk);
		while (axil_rsp.rvalid && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (axil_rsp.rvalid)
			stall("read response release");
		@(posedge clk);
		#2;
		axil_req.rready = 1'b0;
		report_test("read back-pressure", e0);
	endtask

	initial
	begin
		wait (timeout_hit);
		$display("Done: errors found");
		$finish;
	end

	initial
	begin
		clk         = 1'b0;
		arst_n      = 1'b0;
		clk_en      = 1'b0;
		bit_in      = 1'b0;
		axil_req    = '0;
		err_count   = 0;
		test_count  = 0;
		timeout_hit = 1'b0;
		use_gaps    = 1'b0;
		rng_state   = 32'h94cae9de;
		exp_pack    = 8'd0;
		exp_sys     = 8'd0;
		exp_end     = 1'b0;
		pack_payload = '{8'h44, 8'hA1, 8'hB2, 8'hC3, 8'hD5, 8'h81, 8'h23, 8'h45};
		sys_payload  = '{8'h00, 8'h0F, 8'h80, 8'h12, 8'h34, 8'hE1, 8'hFF, 8'hFF,
			8'hC0, 8'hE1, 8'h23, 8'hE0, 8'hF4, 8'h56, 8'hC5, 8'hE0, 8'h80};
		repeat (16) @(posedge clk);
		#2;
		arst_n = 1'b1;
		@(posedge clk);
		#2;
		pack_header_case();
		system_header_case();
		prefix_corner_case();
		clock_enable_case();
		end_and_clear_case();
		read_backpressure_case();
		$display("tests run: %0d, errors: %0d", test_count, err_count);
		if (err_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/mpeg_sys_parser_asserts.sv ====
// protocol checks bound into the parser top
// AXI4-Lite response stability and byte framing spacing

`timescale 1ns/100ps
`default_nettype none

module mpeg_sys_parser_asserts (
	input logic                    clk,
	input logic                    arst_n,
	input logic                    clk_en,
	input logic                    byte_valid,
	input mpeg_sys_pkg::axil_req_t axil_req,
	input mpeg_sys_pkg::axil_rsp_t axil_rsp
);

	logic bv_last; // byte_valid at the previous enabled edge

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			bv_last <= 1'b0;
		else if (clk_en)
			bv_last <= byte_valid;
	end

	rdata_hold: assert property (@(posedge clk) disable iff (!arst_n)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
		else $error("read response changed before rready");

	bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
		else $error("bvalid dropped before bready");

	byte_spacing: assert property (@(posedge clk) disable iff (!arst_n)
		clk_en |-> !(bv_last && byte_valid))
		else $error("byte_valid high on two enabled cycles in a row");

endmodule

bind mpeg_sys_parser_top mpeg_sys_parser_asserts mpeg_sys_parser_asserts_i (
	.clk        (clk),
	.arst_n     (arst_n),
	.clk_en     (clk_en),
	.byte_valid (byte_valid),
	.axil_req   (axil_req),
	.axil_rsp   (axil_rsp)
);

`default_nettype wire

// ==== verilog/mpeg_sys_parser_top.sv ====
// MPEG-1 system stream header parser top
// byte framing and start code scan, header capture, AXI4-Lite results

`timescale 1ns/100ps
`default_nettype none

module mpeg_sys_parser_top (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    clk_en,
	input  logic                    bit_in,
	input  mpeg_sys_pkg::axil_req_t axil_req,
	output mpeg_sys_pkg::axil_rsp_t axil_rsp
);

	logic [7:0] byte_data;
	logic byte_valid;
	mpeg_sys_pkg::code_evt_t code_evt;
	logic pack_start, sys_start, end_hit;
	mpeg_sys_pkg::pack_hdr_t pack_hdr;
	logic pack_done;
	mpeg_sys_pkg::sys_fixed_t sys_fixed;
	mpeg_sys_pkg::bound_table_t bound_table;
	logic sys_done;

	bit_deserializer bit_deserializer_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.clk_en     (clk_en),
		.bit_in     (bit_in),
		.byte_data  (byte_data),
		.byte_valid (byte_valid)
	);

	start_code_scanner start_code_scanner_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.clk_en     (clk_en),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.code_evt   (code_evt)
	);

	// code decode
	assign pack_start = code_evt.valid && (code_evt.code == mpeg_sys_pkg::pack_start_code);
	assign sys_start  = code_evt.valid && (code_evt.code == mpeg_sys_pkg::sys_start_code);
	assign end_hit    = code_evt.valid && (code_evt.code == mpeg_sys_pkg::end_code);

	header_field_capture #(
		.payload_t (mpeg_sys_pkg::pack_hdr_t)
	) pack_capture_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.clk_en     (clk_en),
		.start      (pack_start),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.fields     (pack_hdr),
		.done       (pack_done)
	);

	system_header_parser system_header_parser_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.clk_en      (clk_en),
		.start       (sys_start),
		.byte_data   (byte_data),
		.byte_valid  (byte_valid),
		.sys_fixed   (sys_fixed),
		.bound_table (bound_table),
		.done        (sys_done)
	);

	header_regs_axil header_regs_axil_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.pack_done   (pack_done),
		.sys_done    (sys_done),
		.end_hit     (end_hit),
		.pack_hdr    (pack_hdr),
		.sys_fixed   (sys_fixed),
		.bound_table (bound_table),
		.axil_req    (axil_req),
		.axil_rsp    (axil_rsp)
	);

endmodule

`default_nettype wire

// ==== verilog/header_regs_axil.sv ====
// result register block
// AXI4-Lite slave over the captured headers, done counters and end flag

`timescale 1ns/100ps
`default_nettype none

module header_regs_axil (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       pack_done,
	input  logic                       sys_done,
	input  logic                       end_hit,
	input  mpeg_sys_pkg::pack_hdr_t    pack_hdr,
	input  mpeg_sys_pkg::sys_fixed_t   sys_fixed,
	input  mpeg_sys_pkg::bound_table_t bound_table,
	input  mpeg_sys_pkg::axil_req_t    axil_req,
	output mpeg_sys_pkg::axil_rsp_t    axil_rsp
);

	logic [7:0] pack_count;
	logic [7:0] sys_count;
	logic end_seen;
	logic pack_done_q, sys_done_q, end_hit_q; // stream pulses may span several clocks
	logic wr_acc, rd_acc, clr;
	logic bvalid, rvalid;
	logic [1:0] bresp, rresp;
	logic [31:0] rdata;
	logic [31:0] rd_data;
	logic rd_err;

	assign wr_acc = axil_req.awvalid & axil_req.wvalid & ~bvalid;
	assign rd_acc = axil_req.arvalid & ~rvalid;
	assign clr = wr_acc && (axil_req.awaddr == mpeg_sys_pkg::reg_status)
		&& axil_req.wstrb[0] && axil_req.wdata[0];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pack_done_q <= 1'b0;
			sys_done_q  <= 1'b0;
			end_hit_q   <= 1'b0;
			pack_count  <= 8'd0;
			sys_count   <= 8'd0;
			end_seen    <= 1'b0;
		end
		else
		begin
			pack_done_q <= pack_done;
			sys_done_q  <= sys_done;
			end_hit_q   <= end_hit;
			if (clr)
			begin
				pack_count <= 8'd0;
				sys_count  <= 8'd0;
				end_seen   <= 1'b0;
			end
			else
			begin
				if (pack_done && !pack_done_q && pack_count != 8'hFF)
					pack_count <= pack_count + 8'd1; // saturates
				if (sys_done && !sys_done_q && sys_count != 8'hFF)
					sys_count <= sys_count + 8'd1;
				if (end_hit && !end_hit_q)
					end_seen <= 1'b1;
			end
		end
	end

	always_comb
	begin
		rd_data = 32'd0;
		rd_err  = 1'b0;
		if (axil_req.araddr[7:5] == 3'b001 && axil_req.araddr[1:0] == 2'b00)
			rd_data = {16'd0, bound_table[axil_req.araddr[4:2]]}; // bound table slot
		else
		begin
			case (axil_req.araddr)
				mpeg_sys_pkg::reg_status:     rd_data = {8'd0, sys_count, pack_count, 7'd0, end_seen};
				mpeg_sys_pkg::reg_scr_lo:     rd_data = pack_hdr.scr[31:0];
				mpeg_sys_pkg::reg_scr_hi:     rd_data = {24'd0, pack_hdr.scr[39:32]};
				mpeg_sys_pkg::reg_mux_rate:   rd_data = {8'd0, pack_hdr.mux_rate};
				mpeg_sys_pkg::reg_hdr_len:    rd_data = {16'd0, sys_fixed.hdr_len};
				mpeg_sys_pkg::reg_rate_bound: rd_data = {8'd0, sys_fixed.rate_bound};
				mpeg_sys_pkg::reg_flags:      rd_data = {8'd0, sys_fixed.flags, sys_fixed.reserved};
				default:                      rd_err  = 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bvalid <= 1'b0;
			bresp  <= mpeg_sys_pkg::resp_okay;
			rvalid <= 1'b0;
			rresp  <= mpeg_sys_pkg::resp_okay;
			rdata  <= 32'd0;
		end
		else
		begin
			if (wr_acc)
			begin
				bvalid <= 1'b1;
				bresp  <= (axil_req.awaddr == mpeg_sys_pkg::reg_status) ?
					mpeg_sys_pkg::resp_okay : mpeg_sys_pkg::resp_slverr; // status only
			end
			else if (axil_req.bready)
				bvalid <= 1'b0;
			if (rd_acc)
			begin
				rvalid <= 1'b1;
				rdata  <= rd_data;
				rresp  <= rd_err ? mpeg_sys_pkg::resp_slverr : mpeg_sys_pkg::resp_okay;
			end
			else if (axil_req.rready)
				rvalid <= 1'b0;
		end
	end

	always_comb
	begin
		axil_rsp.awready = wr_acc;
		axil_rsp.wready  = wr_acc;
		axil_rsp.bresp   = bresp;
		axil_rsp.bvalid  = bvalid;
		axil_rsp.arready = rd_acc;
		axil_rsp.rdata   = rdata;
		axil_rsp.rresp   = rresp;
		axil_rsp.rvalid  = rvalid;
	end

endmodule

`default_nettype wire

// ==== verilog/system_header_parser.sv ====
// system header parser
// fixed part through the field capture, then 3-byte stream entries
// written into the buffer bound table by stream_id[2:0]

`timescale 1ns/100ps
`default_nettype none

module system_header_parser (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       clk_en,
	input  logic                       start,
	input  logic [7:0]                 byte_data,
	input  logic                       byte_valid,
	output mpeg_sys_pkg::sys_fixed_t   sys_fixed,
	output mpeg_sys_pkg::bound_table_t bound_table,
	output logic                       done
);

	logic fix_done;
	logic entry_phase;
	logic [15:0] remaining; // bytes left after the fixed part
	logic [1:0] entry_idx;
	logic [15:0] entry_q;   // first two bytes of the entry in progress
	logic done_q;
	mpeg_sys_pkg::stream_entry_t entry_next;

	header_field_capture #(
		.payload_t (mpeg_sys_pkg::sys_fixed_t)
	) fixed_capture_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.clk_en     (clk_en),
		.start      (start),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.fields     (sys_fixed),
		.done       (fix_done)
	);

	assign entry_next = {entry_q, byte_data};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			entry_phase <= 1'b0;
			remaining   <= 16'd0;
			entry_idx   <= 2'd0;
			entry_q     <= 16'd0;
			bound_table <= '0;
			done_q      <= 1'b0;
		end
		else if (clk_en)
		begin
			done_q <= 1'b0;
			if (start)
				entry_phase <= 1'b0; // new header restarts the parse
			else if (fix_done)
			begin
				remaining   <= sys_fixed.hdr_len - 16'd6;
				entry_idx   <= 2'd0;
				entry_phase <= (sys_fixed.hdr_len > 16'd6);
			end
			else if (entry_phase && byte_valid)
			begin
				entry_q   <= {entry_q[7:0], byte_data};
				remaining <= remaining - 16'd1;
				if (entry_idx == 2'd2)
				begin
					entry_idx <= 2'd0;
					// later entry on the same slot overwrites
					bound_table[entry_next.stream_id[2:0]] <= entry_next.buf_bound;
				end
				else
					entry_idx <= entry_idx + 2'd1;
				if (remaining == 16'd1)
				begin
					entry_phase <= 1'b0;
					done_q      <= 1'b1;
				end
			end
		end
	end

	// no entries at all: done together with the fixed part
	assign done = done_q | (fix_done & (sys_fixed.hdr_len == 16'd6));

endmodule

`default_nettype wire

// ==== verilog/header_field_capture.sv ====
// fixed-length header capture
// shifts big-endian bytes after a start pulse into a payload struct

`timescale 1ns/100ps
`default_nettype none

module header_field_capture #(
	parameter type payload_t = mpeg_sys_pkg::pack_hdr_t
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       clk_en,
	input  logic       start,
	input  logic [7:0] byte_data,
	input  logic       byte_valid,
	output payload_t   fields,
	output logic       done
);

	// byte counter sized from the payload width
	typedef logic [$clog2($bits(payload_t)/8)-1:0] cnt_t;

	logic [$bits(payload_t)-1:0] data_q;
	cnt_t byte_cnt;
	logic busy;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			data_q   <= '0;
			byte_cnt <= '0;
			busy     <= 1'b0;
			done     <= 1'b0;
		end
		else if (clk_en)
		begin
			done <= 1'b0;
			if (start)
			begin
				busy     <= 1'b1;
				byte_cnt <= '0;
			end
			else if (busy && byte_valid)
			begin
				data_q <= {data_q[$bits(payload_t)-9:0], byte_data};
				if (byte_cnt == cnt_t'($bits(payload_t)/8 - 1))
				begin
					busy <= 1'b0;
					done <= 1'b1; // struct now full
				end
				else
					byte_cnt <= byte_cnt + 1'b1;
			end
		end
	end

	assign fields = payload_t'(data_q);

endmodule

`default_nettype wire

// ==== verilog/start_code_scanner.sv ====
// start code scanner
// watches the byte stream for the 00 00 01 prefix and reports the byte after it

`timescale 1ns/100ps
`default_nettype none

module start_code_scanner (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   clk_en,
	input  logic [7:0]             byte_data,
	input  logic                   byte_valid,
	output mpeg_sys_pkg::code_evt_t code_evt
);

	typedef enum logic [1:0] {
		st_idle,
		st_zero,     // one 00 seen
		st_two_zero, // 00 00 or longer run
		st_prefix    // 00 00 01 complete
	} scan_state_t;

	scan_state_t state;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= st_idle;
			code_evt <= '0;
		end
		else if (clk_en)
		begin
			code_evt.valid <= 1'b0;
			if (byte_valid)
			begin
				case (state)
					st_idle:
						state <= (byte_data == 8'h00) ? st_zero : st_idle;
					st_zero:
						state <= (byte_data == 8'h00) ? st_two_zero : st_idle;
					st_two_zero:
					begin
						if (byte_data == 8'h01)
							state <= st_prefix;
						else if (byte_data != 8'h00) // extra zeros keep the run alive
							state <= st_idle;
					end
					st_prefix:
					begin
						code_evt.valid <= 1'b1;
						code_evt.code  <= byte_data;
						state          <= st_idle;
					end
					default:
						state <= st_idle;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/bit_deserializer.sv ====
// serial to byte framing
// collects clock-enabled bits MSB first, one valid pulse per byte

`timescale 1ns/100ps
`default_nettype none

module bit_deserializer (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       clk_en,
	input  logic       bit_in,
	output logic [7:0] byte_data,
	output logic       byte_valid
);

	logic [7:0] shift_q;
	logic [2:0] bit_cnt; // framing starts at first enabled bit after reset

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			shift_q    <= 8'h00;
			bit_cnt    <= 3'd0;
			byte_valid <= 1'b0;
		end
		else if (clk_en)
		begin
			shift_q    <= {shift_q[6:0], bit_in};
			bit_cnt    <= bit_cnt + 3'd1;
			byte_valid <= (bit_cnt == 3'd7); // 8th bit just sampled
		end
	end

	// stays put until the next enabled edge
	assign byte_data = shift_q;

endmodule

`default_nettype wire

// ==== verilog/mpeg_sys_pkg.sv ====
// MPEG-1 system stream parser shared definitions
// start codes, header field structs, AXI4-Lite channel structs and register map

`default_nettype none

package mpeg_sys_pkg;

	// byte following the 00 00 01 prefix
	localparam logic [7:0] pack_start_code = 8'hBA;
	localparam logic [7:0] sys_start_code  = 8'hBB;
	localparam logic [7:0] end_code        = 8'hB9;

	localparam int num_slots = 8; // buffer bound table, indexed by stream_id[2:0]

	// first stream byte sits in the top bits
	typedef struct packed {
		logic [39:0] scr;      // raw, marker bits kept
		logic [23:0] mux_rate;
	} pack_hdr_t;

	typedef struct packed {
		logic [15:0] hdr_len;
		logic [23:0] rate_bound;
		logic [15:0] flags;
		logic [7:0]  reserved;
	} sys_fixed_t;

	typedef struct packed {
		logic [7:0]  stream_id;
		logic [15:0] buf_bound; // '11' + scale + 13-bit size
	} stream_entry_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] code;
	} code_evt_t;

	typedef logic [num_slots-1:0][15:0] bound_table_t;

	typedef struct packed {
		logic [7:0]  awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wvalid;
		logic        bready;
		logic [7:0]  araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic [1:0]  bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		logic [1:0]  rresp;
		logic        rvalid;
	} axil_rsp_t;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	localparam logic [7:0] reg_status     = 8'h00; // end_seen, pack_count, sys_count
	localparam logic [7:0] reg_scr_lo     = 8'h04;
	localparam logic [7:0] reg_scr_hi     = 8'h08;
	localparam logic [7:0] reg_mux_rate   = 8'h0C;
	localparam logic [7:0] reg_hdr_len    = 8'h10;
	localparam logic [7:0] reg_rate_bound = 8'h14;
	localparam logic [7:0] reg_flags      = 8'h18;
	localparam logic [7:0] reg_bound_base = 8'h20; // slots at 20..3C

endpackage

`default_nettype wire
